// ==== hdl/dbg_cfg.svh ====
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// TAP identification value
`define DBG_IDCODE      32'h1000_0A6F

// DMI geometry
`define DBG_ABITS       7
`define DBG_DATAW       32
`define DBG_DMI_W       (`DBG_ABITS + `DBG_DATAW + 2)

// DTMCS constant fields
`define DBG_IDLE_HINT   3'd1    // Run-Test/Idle cycles to spend between DMI ops
`define DBG_VERSION     4'd1    // Debug spec 0.13

// Debug-module register file
`define DBG_WAIT_STATES 4       // Extra cycles before ack
`define DBG_RF_DEPTH    16      // Scratch words

`endif

// ==== hdl/dbg_pkg.sv ====
package dbg_pkg;

    // TAP instruction codes
    typedef enum logic [4:0] {
        IR_IDCODE = 5'h01,
        IR_DTMCS  = 5'h10,
        IR_DMI    = 5'h11,
        IR_BYPASS = 5'h1f
    } ir_e;

    // Request op written into the DMI register
    typedef enum logic [1:0] {
        DMI_OP_NOP   = 2'd0,
        DMI_OP_READ  = 2'd1,
        DMI_OP_WRITE = 2'd2
    } dmi_op_e;

    // Status returned in the op field on capture, also used for dmistat
    typedef enum logic [1:0] {
        DMI_STAT_SUCCESS = 2'd0,
        DMI_STAT_FAILED  = 2'd2,
        DMI_STAT_BUSY    = 2'd3
    } dmi_stat_e;

    // Data register routed out of the TAP
    typedef enum logic [1:0] {
        DR_NONE,
        DR_DTMCS,
        DR_DMI
    } dr_sel_e;

    typedef struct packed {
        logic [13:0] zero_hi;
        logic        dmihardreset;
        logic        dmireset;
        logic        zero;
        logic [2:0]  idle;
        dmi_stat_e   dmistat;
        logic [5:0]  abits;
        logic [3:0]  version;
    } dtmcs_t;

endpackage

// ==== hdl/dmi_bus_if.sv ====
`include "dbg_cfg.svh"

// Wishbone-style link between the DTM and the debug-module registers
interface dmi_bus_if;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`DBG_ABITS-1:0] adr;
    logic [`DBG_DATAW-1:0] dat_w;
    logic                  ack;     // One-cycle pulse
    logic [`DBG_DATAW-1:0] dat_r;

    modport master (output cyc, stb, we, adr, dat_w, input ack, dat_r);
    modport slave  (input cyc, stb, we, adr, dat_w, output ack, dat_r);
endinterface

// Custom data register port between the TAP and the DTM
interface tap_dr_if import dbg_pkg::*; ();
    dr_sel_e               sel;
    logic                  capture;     // Capture-DR pulse
    logic                  update;      // Update-DR pulse
    logic [`DBG_DMI_W-1:0] wdata;       // Shift register contents
    logic [`DBG_DMI_W-1:0] rdata;       // Parallel load value
    logic [5:0]            width;       // Length of the selected register

    modport master (output sel, capture, update, wdata, input rdata, width);
    modport target (input sel, capture, update, wdata, output rdata, width);
endinterface

// ==== hdl/jtag_tap.sv ====
`include "dbg_cfg.svh"

module jtag_tap import dbg_pkg::*; (
    input  logic      tck_i,
    input  logic      trst_n_i,
    input  logic      tms_i,
    input  logic      tdi_i,
    output logic      tdo_o,
    tap_dr_if.master  dr
);

    localparam int DR_W = `DBG_DMI_W;

    typedef enum logic [3:0] {
        TLR, RTI,
        SEL_DR, CAP_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR, UPD_DR,
        SEL_IR, CAP_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPD_IR
    } tap_state_e;

    tap_state_e      state_q;
    tap_state_e      state_d;
    logic [4:0]      ir_q;          // Active instruction
    logic [4:0]      ir_sr;         // IR shift stage
    logic [DR_W-1:0] dr_sr;
    logic [DR_W-1:0] dr_next;
    logic            bypass_q;
    logic            is_idcode;
    logic            is_bypass;
    logic [5:0]      dr_len;

    //////////////////////////////////////////////////////////////////////
    // TAP controller
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state_q)
            TLR:      state_d = tms_i ? TLR      : RTI;
            RTI:      state_d = tms_i ? SEL_DR   : RTI;
            SEL_DR:   state_d = tms_i ? SEL_IR   : CAP_DR;
            CAP_DR:   state_d = tms_i ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR: state_d = tms_i ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR: state_d = tms_i ? UPD_DR   : PAUSE_DR;
            PAUSE_DR: state_d = tms_i ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR: state_d = tms_i ? UPD_DR   : SHIFT_DR;
            UPD_DR:   state_d = tms_i ? SEL_DR   : RTI;
            SEL_IR:   state_d = tms_i ? TLR      : CAP_IR;
            CAP_IR:   state_d = tms_i ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR: state_d = tms_i ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR: state_d = tms_i ? UPD_IR   : PAUSE_IR;
            PAUSE_IR: state_d = tms_i ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR: state_d = tms_i ? UPD_IR   : SHIFT_IR;
            default:  state_d = tms_i ? SEL_DR   : RTI;     // UPD_IR
        endcase
    end

    // Instruction decode, unknown codes behave as BYPASS
    always_comb begin
        case (ir_q)
            IR_DTMCS: dr.sel = DR_DTMCS;
            IR_DMI:   dr.sel = DR_DMI;
            default:  dr.sel = DR_NONE;
        endcase
    end

    assign is_idcode = (ir_q == IR_IDCODE);
    assign is_bypass = !is_idcode && (dr.sel == DR_NONE);
    assign dr_len    = is_idcode ? 6'd32 : dr.width;

    // New bit enters at the top of the selected register
    always_comb begin
        dr_next = {1'b0, dr_sr[DR_W-1:1]};
        dr_next[dr_len - 6'd1] = tdi_i;
    end

    assign dr.capture = (state_q == CAP_DR);
    assign dr.update  = (state_q == UPD_DR);
    assign dr.wdata   = dr_sr;

    always_ff @(posedge tck_i) begin
        if (!trst_n_i) begin
            state_q <= TLR;
            ir_q    <= IR_IDCODE;
            ir_sr   <= '0;
            tdo_o   <= 1'b0;
        end else begin
            state_q <= state_d;
            case (state_q)
                TLR:      ir_q  <= IR_IDCODE;
                CAP_IR:   ir_sr <= IR_IDCODE;
                SHIFT_IR: begin
                    ir_sr <= {tdi_i, ir_sr[4:1]};
                    tdo_o <= ir_sr[0];
                end
                UPD_IR:   ir_q  <= ir_sr;
                SHIFT_DR: tdo_o <= is_bypass ? bypass_q : dr_sr[0];
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge tck_i) begin
        if (state_q == CAP_DR) begin
            bypass_q <= 1'b0;
            if (is_idcode)
                dr_sr <= {{(DR_W-32){1'b0}}, `DBG_IDCODE};
            else
                dr_sr <= dr.rdata;
        end else if (state_q == SHIFT_DR) begin
            bypass_q <= tdi_i;
            if (!is_bypass)
                dr_sr <= dr_next;
        end
    end

    // Five TMS-high edges reach Test-Logic-Reset from any state
    a_tms_reset: assert property (@(posedge tck_i) disable iff (!trst_n_i)
        tms_i [*5] |=> state_q == TLR);

endmodule

// ==== hdl/dtm.sv ====
`include "dbg_cfg.svh"

module dtm import dbg_pkg::*; (
    input  logic       tck_i,
    input  logic       trst_n_i,
    tap_dr_if.target   dr,
    dmi_bus_if.master  bus
);

    localparam int DR_W = `DBG_DMI_W;

    logic [`DBG_ABITS-1:0] addr_q;
    logic [`DBG_DATAW-1:0] data_q;
    logic                  we_q;
    logic                  cyc_q;       // Bus cycle pending
    dmi_stat_e             dmistat_q;
    dmi_stat_e             cap_op;
    dmi_op_e               op_in;
    dtmcs_t                dtmcs;
    dtmcs_t                dtmcs_wr;
    logic                  dmi_access;
    logic                  dmi_upd;
    logic                  dtmcs_upd;

    //////////////////////////////////////////////////////////////////////
    // Register views seen by the TAP
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dtmcs         = '0;
        dtmcs.idle    = `DBG_IDLE_HINT;
        dtmcs.dmistat = dmistat_q;
        dtmcs.abits   = 6'(`DBG_ABITS);
        dtmcs.version = `DBG_VERSION;
    end

    assign cap_op = cyc_q ? DMI_STAT_BUSY : dmistat_q;

    always_comb begin
        case (dr.sel)
            DR_DTMCS: begin
                dr.rdata = {{(DR_W-32){1'b0}}, dtmcs};
                dr.width = 6'd32;
            end
            DR_DMI: begin
                dr.rdata = {addr_q, data_q, cap_op};
                dr.width = 6'(DR_W);
            end
            default: begin
                dr.rdata = '0;
                dr.width = 6'd1;
            end
        endcase
    end

    assign op_in      = dmi_op_e'(dr.wdata[1:0]);
    assign dtmcs_wr   = dtmcs_t'(dr.wdata[31:0]);
    assign dmi_access = (dr.sel == DR_DMI) && (dr.capture || dr.update);
    assign dmi_upd    = (dr.sel == DR_DMI) && dr.update;
    assign dtmcs_upd  = (dr.sel == DR_DTMCS) && dr.update;

    //////////////////////////////////////////////////////////////////////
    // DMI operation and bus master
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge tck_i) begin
        if (!trst_n_i) begin
            cyc_q     <= 1'b0;
            we_q      <= 1'b0;
            addr_q    <= '0;
            data_q    <= '0;
            dmistat_q <= DMI_STAT_SUCCESS;
        end else begin
            if (cyc_q && bus.ack) begin
                cyc_q <= 1'b0;
                if (!we_q)
                    data_q <= bus.dat_r;    // Read result for the next capture
            end

            if (dmi_access && cyc_q) begin
                dmistat_q <= DMI_STAT_BUSY;     // Sticky until dmireset
            end else if (dmi_upd && dmistat_q == DMI_STAT_SUCCESS &&
                         (op_in == DMI_OP_READ || op_in == DMI_OP_WRITE)) begin
                cyc_q  <= 1'b1;
                we_q   <= (op_in == DMI_OP_WRITE);
                data_q <= dr.wdata[2 +: `DBG_DATAW];
                addr_q <= dr.wdata[2 + `DBG_DATAW +: `DBG_ABITS];
            end

            if (dtmcs_upd) begin
                if (dtmcs_wr.dmireset || dtmcs_wr.dmihardreset)
                    dmistat_q <= DMI_STAT_SUCCESS;
                if (dtmcs_wr.dmihardreset)
                    cyc_q <= 1'b0;      // Abandon the pending cycle
            end
        end
    end

    assign bus.cyc   = cyc_q;
    assign bus.stb   = cyc_q;
    assign bus.we    = we_q;
    assign bus.adr   = addr_q;
    assign bus.dat_w = data_q;

    // A cycle only starts right after a DMI update
    a_stb_on_upd: assert property (@(posedge tck_i) disable iff (!trst_n_i)
        $rose(bus.stb) |-> $past(dmi_upd));

    // Address held for the whole strobe
    a_adr_stable: assert property (@(posedge tck_i) disable iff (!trst_n_i)
        $past(bus.stb) && bus.stb |-> $stable(bus.adr));

endmodule

// ==== hdl/dm_regfile.sv ====
`include "dbg_cfg.svh"

module dm_regfile (
    input  logic      tck_i,
    input  logic      trst_n_i,
    dmi_bus_if.slave  bus
);

    localparam int DEPTH = `DBG_RF_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(`DBG_WAIT_STATES + 2);

    logic [`DBG_DATAW-1:0] mem [DEPTH];
    logic [CNT_W-1:0]      wait_cnt;
    logic                  ack_q;
    logic [`DBG_DATAW-1:0] dat_r_q;
    logic                  in_range;
    logic [IDX_W-1:0]      idx;
    logic                  fire;        // Access completes on this edge

    assign in_range = (bus.adr < DEPTH);
    assign idx      = bus.adr[IDX_W-1:0];
    assign fire     = bus.cyc && bus.stb && !ack_q &&
                      (wait_cnt == CNT_W'(`DBG_WAIT_STATES));

    always_ff @(posedge tck_i) begin
        if (!trst_n_i) begin
            wait_cnt <= '0;
            ack_q    <= 1'b0;
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= '0;
        end else begin
            ack_q <= fire;
            if (!bus.stb || ack_q || fire) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            if (fire && bus.we && in_range)
                mem[idx] <= bus.dat_w;      // Out of range writes dropped
        end
    end

    always_ff @(posedge tck_i) begin
        if (fire)
            dat_r_q <= in_range ? mem[idx] : '0;
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = dat_r_q;

    // Master keeps the strobe up until the ack arrives
    a_ack_stb: assert property (@(posedge tck_i) disable iff (!trst_n_i)
        bus.ack |-> bus.stb);

endmodule

// ==== hdl/dbg_top.sv ====
module dbg_top (
    input  logic tck_i,
    input  logic trst_n_i,
    input  logic tms_i,
    input  logic tdi_i,
    output logic tdo_o
);

    tap_dr_if  dr_if ();
    dmi_bus_if bus_if ();

    jtag_tap tap (
        .tck_i    (tck_i),
        .trst_n_i (trst_n_i),
        .tms_i    (tms_i),
        .tdi_i    (tdi_i),
        .tdo_o    (tdo_o),
        .dr       (dr_if.master)
    );

    dtm dtm (
        .tck_i    (tck_i),
        .trst_n_i (trst_n_i),
        .dr       (dr_if.target),
        .bus      (bus_if.master)
    );

    dm_regfile regfile (
        .tck_i    (tck_i),
        .trst_n_i (trst_n_i),
        .bus      (bus_if.slave)
    );

endmodule

// ==== tb/tb_clkgen.sv ====
module tb_clkgen (
    output logic tck_o,
    output logic trst_n_o
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_NS    = 10;     // 20 ns tck period
    localparam int RST_CYCLES = 10;

    initial begin
        tck_o = 1'b0;
        forever #HALF_NS tck_o = ~tck_o;
    end

    // Release on a falling edge so the first rising edge sees a clean level
    initial begin
        trst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge tck_o);
        @(negedge tck_o);
        trst_n_o = 1'b1;
    end

endmodule

// ==== tb/tb_dbg.sv ====
`include "dbg_cfg.svh"

module tb_dbg import dbg_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DW           = `DBG_DMI_W;
    localparam int AW           = `DBG_ABITS;
    localparam int TCK_NS       = 20;
    localparam int N_TESTS      = 6;
    localparam int SCAN_CYC     = DW + 24;          // DR scan, idle and an IR change
    localparam int WATCHDOG_CYC = N_TESTS * 20 * SCAN_CYC;  // Longest test needs ~18 scans

    logic        tck;
    logic        trst_n;
    logic        tms;
    logic        tdi;
    logic        tdo;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    logic [31:0] model [`DBG_RF_DEPTH];     // Expected scratch contents

    tb_clkgen clkgen (
        .tck_o    (tck),
        .trst_n_o (trst_n)
    );

    dbg_top dut (
        .tck_i    (tck),
        .trst_n_i (trst_n),
        .tms_i    (tms),
        .tdi_i    (tdi),
        .tdo_o    (tdo)
    );

    //////////////////////////////////////////////////////////////////////
    // JTAG pin access
    //////////////////////////////////////////////////////////////////////

    // Called on a falling edge, returns TDO as registered by the rising edge
    task automatic jtag_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
        tms = tms_v;
        tdi = tdi_v;
        @(negedge tck);
        tdo_v = tdo;
    endtask

    task automatic run_idle(input int cycles);
        logic d;
        repeat (cycles) jtag_step(1'b0, 1'b0, d);
    endtask

    task automatic tap_reset();
        logic d;
        repeat (5) jtag_step(1'b1, 1'b0, d);
        jtag_step(1'b0, 1'b0, d);           // On to Run-Test/Idle
    endtask

    task automatic shift_ir(input logic [4:0] ir);
        logic d;
        jtag_step(1'b1, 1'b0, d);           // Select-DR
        jtag_step(1'b1, 1'b0, d);           // Select-IR
        jtag_step(1'b0, 1'b0, d);           // Capture-IR
        jtag_step(1'b0, 1'b0, d);
        for (int i = 0; i < 5; i++)
            jtag_step(i == 4, ir[i], d);
        jtag_step(1'b1, 1'b0, d);           // Update-IR
        jtag_step(1'b0, 1'b0, d);
    endtask

    // Shifts len bits LSB first, returns what came out of TDO
    task automatic shift_dr(input int len, input logic [DW-1:0] din,
                            output logic [DW-1:0] dout);
        logic d;
        dout = '0;
        jtag_step(1'b1, 1'b0, d);           // Select-DR
        jtag_step(1'b0, 1'b0, d);           // Capture-DR
        jtag_step(1'b0, 1'b0, d);
        for (int i = 0; i < len; i++) begin
            jtag_step(i == len - 1, din[i], d);
            dout[i] = d;
        end
        jtag_step(1'b1, 1'b0, d);           // Update-DR
        jtag_step(1'b0, 1'b0, d);
    endtask

    task automatic dmi_scan(input logic [AW-1:0] addr, input logic [31:0] data,
                            input logic [1:0] op, input int idle_cyc,
                            output logic [DW-1:0] cap);
        shift_dr(DW, {addr, data, op}, cap);
        run_idle(idle_cyc);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checking and reporting
    //////////////////////////////////////////////////////////////////////

    task automatic check_val(input string name, input logic [63:0] expv,
                             input logic [63:0] got);
        assert (got === expv)
        else begin
            $display("error at %0t: %s expected %h, got %h", $time, name, expv, got);
            err_cnt++;
        end
    endtask

    // DTMCS as laid out by the debug spec: idle 1, abits 7, version 1
    function automatic logic [31:0] dtmcs_expect(input logic [1:0] stat);
        return {14'd0, 3'b000, 3'd1, stat, 6'd7, 4'd1};
    endfunction

    // Read, then a NOP scan to capture the result
    task automatic read_check(input logic [AW-1:0] addr, input logic [31:0] expv);
        logic [DW-1:0] cap;
        dmi_scan(addr, '0, DMI_OP_READ, 8, cap);
        dmi_scan('0, '0, DMI_OP_NOP, 8, cap);
        check_val("dmi data", expv, cap[2 +: 32]);
        check_val("dmi op", 2'd0, cap[1:0]);
    endtask

    task automatic end_test(input int num, input string name);
        if (err_cnt == 0) begin
            pass_cnt++;
            $display("test %0d %-34s ok", num, name);
        end else begin
            fail_cnt++;
            $display("test %0d %-34s FAIL (%0d errors)", num, name, err_cnt);
        end
        err_cnt = 0;
    endtask

    initial begin
        #(WATCHDOG_CYC * TCK_NS);
        $display("timeout: run still going after %0d tck cycles", WATCHDOG_CYC);
        $display("tests failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [DW-1:0]   cap;
        logic [15:0]     pat;
        logic [AW-1:0]   addr [5];
        logic [AW-1:0]   a;
        logic [AW-1:0]   b;
        logic [31:0]     data;

        tms      = 1'b1;
        tdi      = 1'b0;
        err_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        void'($urandom(20));
        foreach (model[i])
            model[i] = '0;
        wait (trst_n === 1'b1);
        @(negedge tck);
        tap_reset();

        // IR holds IDCODE straight out of reset
        shift_dr(32, '0, cap);
        check_val("tdo idcode", `DBG_IDCODE, cap[31:0]);
        end_test(1, "idcode after reset");

        pat = 16'($urandom());
        shift_ir(IR_BYPASS);
        shift_dr(16, DW'(pat), cap);
        check_val("tdo bypass", {pat[14:0], 1'b0}, cap[15:0]);
        pat = 16'($urandom());
        shift_ir(5'h05);                    // Unused code
        shift_dr(16, DW'(pat), cap);
        check_val("tdo unused ir", {pat[14:0], 1'b0}, cap[15:0]);
        tap_reset();
        shift_dr(32, '0, cap);
        check_val("tdo idcode after tms reset", `DBG_IDCODE, cap[31:0]);
        end_test(2, "bypass and tms reset");

        shift_ir(IR_DTMCS);
        shift_dr(32, '0, cap);
        check_val("dtmcs", dtmcs_expect(2'd0), cap[31:0]);
        end_test(3, "dtmcs fields");

        shift_ir(IR_DMI);
        for (int i = 0; i < 5; i++) begin
            addr[i] = AW'($urandom_range(0, `DBG_RF_DEPTH - 1));
            data    = $urandom();
            dmi_scan(addr[i], data, DMI_OP_WRITE, 8, cap);
            model[addr[i][3:0]] = data;
        end
        for (int i = 0; i < 5; i++)
            read_check(addr[i], model[addr[i][3:0]]);
        a = AW'($urandom_range(`DBG_RF_DEPTH, 127));
        dmi_scan(a, $urandom(), DMI_OP_WRITE, 8, cap);    // Dropped by the target
        read_check(a, 32'd0);
        end_test(4, "dmi write and read back");

        a    = AW'($urandom_range(0, `DBG_RF_DEPTH - 1));
        b    = AW'((a + 1) % `DBG_RF_DEPTH);
        data = $urandom();
        dmi_scan(a, data, DMI_OP_WRITE, 0, cap);
        dmi_scan(b, $urandom(), DMI_OP_WRITE, 8, cap);    // Lands on a pending cycle
        check_val("dmi op", 2'd3, cap[1:0]);
        model[a[3:0]] = data;
        shift_ir(IR_DTMCS);
        shift_dr(32, DW'(32'h1 << 16), cap);               // dmireset
        check_val("dtmcs", dtmcs_expect(2'd3), cap[31:0]);
        shift_dr(32, '0, cap);
        check_val("dtmcs", dtmcs_expect(2'd0), cap[31:0]);
        shift_ir(IR_DMI);
        read_check(b, model[b[3:0]]);
        read_check(a, data);
        end_test(5, "busy and dmireset");

        a = AW'($urandom_range(0, `DBG_RF_DEPTH - 1));
        dmi_scan(a, $urandom(), DMI_OP_WRITE, 0, cap);
        dmi_scan('0, '0, DMI_OP_NOP, 8, cap);
        check_val("dmi op", 2'd3, cap[1:0]);
        shift_ir(IR_DTMCS);
        shift_dr(32, DW'(32'h1 << 17), cap);               // dmihardreset
        check_val("dtmcs", dtmcs_expect(2'd3), cap[31:0]);
        shift_dr(32, '0, cap);
        check_val("dtmcs", dtmcs_expect(2'd0), cap[31:0]);
        shift_ir(IR_DMI);
        data = $urandom();
        dmi_scan(a, data, DMI_OP_WRITE, 8, cap);
        model[a[3:0]] = data;
        read_check(a, data);
        end_test(6, "dmihardreset clears busy");

        $display("%0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/dbg_pkg.sv
hdl/dmi_bus_if.sv
hdl/jtag_tap.sv
hdl/dtm.sv
hdl/dm_regfile.sv
hdl/dbg_top.sv
tb/tb_clkgen.sv
tb/tb_dbg.sv

// ==== Bender.yml ====
package:
  name: dbg_transport

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/dbg_pkg.sv
      - hdl/dmi_bus_if.sv
      - hdl/jtag_tap.sv
      - hdl/dtm.sv
      - hdl/dm_regfile.sv
      - hdl/dbg_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/tb_dbg.sv
